//--- logic/exec_pkg.sv
package exec_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0] byte_en_t;

  typedef enum logic [3:0] {
    INSTR_INVAL,
    INSTR_LUI,
    INSTR_AUIPC,
    INSTR_JAL,
    INSTR_JALR,
    INSTR_BRANCH,
    INSTR_LOAD,
    INSTR_STORE,
    INSTR_OP_IMM,
    INSTR_OP,
    INSTR_SYSTEM
  } instr_op_e;

  // ALU function as encoded by funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SR   = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_func_e;

  // For SYSTEM the decoder puts the CSR address in imm[11:0] and the 5-bit uimm in imm[16:12]
  typedef struct packed {
    instr_op_e op;
    logic [2:0] funct3;
    logic funct7_b5;
    reg_idx_t rd;
    xlen_t rs1_val;
    xlen_t rs2_val;
    xlen_t imm;
    xlen_t pc;
  } decoded_instr;

  typedef struct packed {
    logic rd_write;
    reg_idx_t rd;
    xlen_t rd_val;
    logic redirect;
    xlen_t redirect_target;
    logic trap;
  } exec_result;

  typedef enum logic [1:0] {
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_e;

  typedef struct packed {
    csr_addr_t addr;
    csr_op_e op;
    xlen_t operand;
  } csr_req_t;

  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_CYCLE    = 12'hc00;

  localparam xlen_t MTVEC_RESET = 32'h0000_0100;

endpackage

//--- logic/exec_unit_if.sv
interface exec_unit_if import exec_pkg::*; ();

  logic valid;
  logic ready;
  decoded_instr instr;
  exec_result result;

  modport dispatch (
    output valid,
    output instr,
    input ready,
    input result
  );

  modport unit (
    input valid,
    input instr,
    output ready,
    output result
  );

endinterface

//--- logic/exec_dispatch.sv
module exec_dispatch import exec_pkg::*; (
  input logic clk,
  input logic reset,
  input logic in_valid,
  output logic in_ready,
  input decoded_instr in_instr,
  output logic out_valid,
  input logic out_ready,
  output exec_result out_result,
  exec_unit_if.dispatch alu_port,
  exec_unit_if.dispatch misc_port,
  exec_unit_if.dispatch pcrel_port,
  exec_unit_if.dispatch mem_port,
  exec_unit_if.dispatch csr_port
);

  logic sel_alu;
  logic sel_misc;
  logic sel_pcrel;
  logic sel_mem;
  logic sel_csr;

  always_comb begin
    sel_alu = 1'b0;
    sel_misc = 1'b0;
    sel_pcrel = 1'b0;
    sel_mem = 1'b0;
    sel_csr = 1'b0;
    unique case (in_instr.op)
      INSTR_OP, INSTR_OP_IMM: sel_alu = 1'b1;
      INSTR_AUIPC, INSTR_JAL, INSTR_BRANCH: sel_pcrel = 1'b1;
      INSTR_LOAD, INSTR_STORE: sel_mem = 1'b1;
      INSTR_SYSTEM: begin
        sel_csr = in_instr.funct3 != 3'b000; // funct3 zero is ECALL and friends
        sel_misc = in_instr.funct3 == 3'b000;
      end
      default: sel_misc = 1'b1; // LUI, JALR, INVAL and unused encodings
    endcase
  end

  assign alu_port.instr = in_instr;
  assign misc_port.instr = in_instr;
  assign pcrel_port.instr = in_instr;
  assign mem_port.instr = in_instr;
  assign csr_port.instr = in_instr;

  assign alu_port.valid = in_valid && sel_alu;
  assign misc_port.valid = in_valid && sel_misc;
  assign pcrel_port.valid = in_valid && sel_pcrel;
  assign mem_port.valid = in_valid && sel_mem;
  assign csr_port.valid = in_valid && sel_csr;

  always_comb begin
    in_ready = misc_port.ready;
    out_result = misc_port.result;
    if (sel_alu) begin
      in_ready = alu_port.ready;
      out_result = alu_port.result;
    end else if (sel_pcrel) begin
      in_ready = pcrel_port.ready;
      out_result = pcrel_port.result;
    end else if (sel_mem) begin
      in_ready = mem_port.ready;
      out_result = mem_port.result;
    end else if (sel_csr) begin
      in_ready = csr_port.ready;
      out_result = csr_port.result;
    end
  end

  assign out_valid = in_valid && in_ready; // result leaves with the input transfer

  // the result channel has no buffer, so the environment may never stall it
  assert property (@(posedge clk) disable iff (reset) out_valid |-> out_ready);

  assert property (@(posedge clk) disable iff (reset)
    $onehot0({alu_port.valid, misc_port.valid, pcrel_port.valid, mem_port.valid,
              csr_port.valid}));

endmodule

//--- logic/exec_alu.sv
module exec_alu import exec_pkg::*; (
  input logic clk,
  input logic reset,
  exec_unit_if.unit port
);

  xlen_t op_a;
  xlen_t op_b;
  xlen_t res;
  alu_func_e func;

  assign op_a = port.instr.rs1_val;
  assign op_b = (port.instr.op == INSTR_OP) ? port.instr.rs2_val : port.instr.imm;
  assign func = alu_func_e'(port.instr.funct3);

  always_comb begin
    unique case (func)
      ALU_ADD: begin
        if (port.instr.op == INSTR_OP && port.instr.funct7_b5) begin
          res = op_a - op_b;
        end else begin
          res = op_a + op_b; // addi never subtracts
        end
      end
      ALU_SLL: res = op_a << op_b[4:0];
      ALU_SLT: res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: res = {31'b0, op_a < op_b};
      ALU_XOR: res = op_a ^ op_b;
      ALU_SR: begin
        if (port.instr.funct7_b5) begin
          res = xlen_t'($signed(op_a) >>> op_b[4:0]);
        end else begin
          res = op_a >> op_b[4:0];
        end
      end
      ALU_OR: res = op_a | op_b;
      ALU_AND: res = op_a & op_b;
    endcase
  end

  assign port.ready = 1'b1;

  always_comb begin
    port.result = '0;
    port.result.rd_write = 1'b1;
    port.result.rd = port.instr.rd;
    port.result.rd_val = res;
  end

  // the dispatcher only routes integer register ops here
  assert property (@(posedge clk) disable iff (reset)
    port.valid |-> port.instr.op inside {INSTR_OP, INSTR_OP_IMM});

endmodule

//--- logic/exec_misc.sv
module exec_misc import exec_pkg::*; (
  input logic clk,
  input logic reset,
  exec_unit_if.unit port
);

  xlen_t jalr_target;

  assign jalr_target = (port.instr.rs1_val + port.instr.imm) & ~xlen_t'(1);
  assign port.ready = 1'b1;

  always_comb begin
    port.result = '0;
    port.result.rd = port.instr.rd;
    case (port.instr.op)
      INSTR_LUI: begin
        port.result.rd_write = 1'b1;
        port.result.rd_val = port.instr.imm;
      end
      INSTR_JALR: begin
        port.result.rd_write = 1'b1;
        port.result.rd_val = port.instr.pc + 32'd4;
        port.result.redirect = 1'b1;
        port.result.redirect_target = jalr_target;
      end
      default: port.result.trap = 1'b1; // nothing else is implemented here
    endcase
  end

  // CSR forms of SYSTEM must have gone to the CSR unit
  assert property (@(posedge clk) disable iff (reset)
    port.valid && port.instr.op == INSTR_SYSTEM |-> port.instr.funct3 == 3'b000);

endmodule

//--- logic/exec_pcrel.sv
module exec_pcrel import exec_pkg::*; (
  input logic clk,
  input logic reset,
  exec_unit_if.unit port
);

  xlen_t rs1;
  xlen_t rs2;
  xlen_t target;
  logic taken;
  logic bad_cond;

  assign rs1 = port.instr.rs1_val;
  assign rs2 = port.instr.rs2_val;
  assign target = port.instr.pc + port.instr.imm;

  always_comb begin
    taken = 1'b0;
    bad_cond = 1'b0;
    case (port.instr.funct3)
      3'b000: taken = rs1 == rs2;
      3'b001: taken = rs1 != rs2;
      3'b100: taken = $signed(rs1) < $signed(rs2);
      3'b101: taken = $signed(rs1) >= $signed(rs2);
      3'b110: taken = rs1 < rs2;
      3'b111: taken = rs1 >= rs2;
      default: bad_cond = 1'b1; // funct3 2 and 3 are not branches
    endcase
  end

  assign port.ready = 1'b1;

  always_comb begin
    port.result = '0;
    port.result.rd = port.instr.rd;
    port.result.redirect_target = target;
    case (port.instr.op)
      INSTR_AUIPC: begin
        port.result.rd_write = 1'b1;
        port.result.rd_val = target;
      end
      INSTR_JAL: begin
        port.result.rd_write = 1'b1;
        port.result.rd_val = port.instr.pc + 32'd4;
        port.result.redirect = 1'b1;
      end
      default: begin
        port.result.trap = bad_cond;
        port.result.redirect = taken;
      end
    endcase
  end

  assert property (@(posedge clk) disable iff (reset)
    port.valid |-> port.instr.op inside {INSTR_AUIPC, INSTR_JAL, INSTR_BRANCH});

endmodule

//--- logic/exec_mem.sv
module exec_mem import exec_pkg::*; (
  input logic clk,
  input logic reset,
  exec_unit_if.unit port,
  output logic mem_req_valid,
  input logic mem_req_ready,
  output logic mem_req_write,
  output xlen_t mem_req_addr,
  output xlen_t mem_req_wdata,
  output byte_en_t mem_req_be,
  input logic mem_resp_valid,
  input xlen_t mem_resp_rdata,
  output logic mem_resp_ready
);

  typedef enum logic {REQ, WAIT} mem_state_e;

  mem_state_e state;
  xlen_t addr;
  xlen_t lane;
  xlen_t load_val;
  logic is_store;

  assign is_store = port.instr.op == INSTR_STORE;
  assign addr = port.instr.rs1_val + port.instr.imm;

  assign mem_req_valid = port.valid && state == REQ;
  assign mem_req_write = is_store;
  assign mem_req_addr = addr;
  assign mem_req_wdata = port.instr.rs2_val << {addr[1:0], 3'b000};

  always_comb begin
    case (port.instr.funct3[1:0])
      2'b00: mem_req_be = 4'b0001 << addr[1:0];
      2'b01: mem_req_be = 4'b0011 << addr[1:0];
      default: mem_req_be = 4'b1111;
    endcase
  end

  assign mem_resp_ready = state == WAIT;
  assign lane = mem_resp_rdata >> {addr[1:0], 3'b000}; // addressed lane down to bit 0

  always_comb begin
    case (port.instr.funct3)
      3'b000: load_val = {{24{lane[7]}}, lane[7:0]};
      3'b001: load_val = {{16{lane[15]}}, lane[15:0]};
      3'b100: load_val = {24'b0, lane[7:0]};
      3'b101: load_val = {16'b0, lane[15:0]};
      default: load_val = lane;
    endcase
  end

  assign port.ready = state == WAIT && mem_resp_valid; // stores wait for the ack too

  always_comb begin
    port.result = '0;
    port.result.rd_write = !is_store;
    port.result.rd = port.instr.rd;
    port.result.rd_val = load_val;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= REQ;
    end else begin
      case (state)
        REQ: if (mem_req_valid && mem_req_ready) state <= WAIT;
        WAIT: if (mem_resp_valid) state <= REQ;
      endcase
    end
  end

  // relies on the decoder holding in_instr while the stage is stalled
  assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr)
      && $stable(mem_req_write) && $stable(mem_req_wdata) && $stable(mem_req_be));

endmodule

//--- logic/exec_csr.sv
module exec_csr import exec_pkg::*; (
  input logic clk,
  input logic reset,
  exec_unit_if.unit port,
  output logic csr_req_valid,
  input logic csr_req_ready,
  output csr_req_t csr_req,
  input logic csr_resp_valid,
  input xlen_t csr_resp_rdata
);

  logic pending;

  assign csr_req.addr = port.instr.imm[11:0];
  assign csr_req.operand = port.instr.funct3[2] ? {27'b0, port.instr.imm[16:12]}
                                                : port.instr.rs1_val;

  always_comb begin
    case (port.instr.funct3[1:0])
      2'b01: csr_req.op = CSR_WRITE;
      2'b11: csr_req.op = CSR_CLEAR;
      default: csr_req.op = CSR_SET;
    endcase
  end

  assign csr_req_valid = port.valid && !pending;
  assign port.ready = pending && csr_resp_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (csr_req_valid && csr_req_ready) begin
      pending <= 1'b1;
    end else if (csr_resp_valid) begin
      pending <= 1'b0;
    end
  end

  always_comb begin
    port.result = '0;
    port.result.rd_write = 1'b1;
    port.result.rd = port.instr.rd;
    port.result.rd_val = csr_resp_rdata; // old value of the CSR
  end

endmodule

//--- logic/csr_file.sv
module csr_file import exec_pkg::*; (
  input logic clk,
  input logic reset,
  input logic csr_req_valid,
  output logic csr_req_ready,
  input csr_req_t csr_req,
  output logic csr_resp_valid,
  output xlen_t csr_resp_rdata
);

  xlen_t mscratch;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t cycle;
  xlen_t old_val;
  xlen_t new_val;

  assign csr_req_ready = 1'b1;

  always_comb begin
    case (csr_req.addr)
      CSR_MSCRATCH: old_val = mscratch;
      CSR_MTVEC: old_val = mtvec;
      CSR_MEPC: old_val = mepc;
      CSR_MCAUSE: old_val = mcause;
      CSR_CYCLE: old_val = cycle;
      default: old_val = '0;
    endcase
  end

  always_comb begin
    case (csr_req.op)
      CSR_WRITE: new_val = csr_req.operand;
      CSR_SET: new_val = old_val | csr_req.operand;
      default: new_val = old_val & ~csr_req.operand;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mscratch <= '0;
      mtvec <= MTVEC_RESET;
      mepc <= '0;
      mcause <= '0;
      cycle <= '0;
      csr_resp_valid <= 1'b0;
    end else begin
      cycle <= cycle + 32'd1;
      csr_resp_valid <= csr_req_valid;
      if (csr_req_valid) begin
        case (csr_req.addr) // cycle is read only
          CSR_MSCRATCH: mscratch <= new_val;
          CSR_MTVEC: mtvec <= new_val;
          CSR_MEPC: mepc <= new_val;
          CSR_MCAUSE: mcause <= new_val;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (csr_req_valid) csr_resp_rdata <= old_val;
  end

endmodule

//--- logic/exec_top.sv
module exec_top import exec_pkg::*; (
  input logic clk,
  input logic reset,
  input logic in_valid,
  output logic in_ready,
  input decoded_instr in_instr,
  output logic out_valid,
  input logic out_ready,
  output exec_result out_result,
  output logic mem_req_valid,
  input logic mem_req_ready,
  output logic mem_req_write,
  output xlen_t mem_req_addr,
  output xlen_t mem_req_wdata,
  output byte_en_t mem_req_be,
  input logic mem_resp_valid,
  input xlen_t mem_resp_rdata,
  output logic mem_resp_ready
);

  logic csr_req_valid;
  logic csr_req_ready;
  csr_req_t csr_req;
  logic csr_resp_valid;
  xlen_t csr_resp_rdata;

  exec_unit_if alu_if ();
  exec_unit_if misc_if ();
  exec_unit_if pcrel_if ();
  exec_unit_if mem_if ();
  exec_unit_if csr_if ();

  exec_dispatch dispatch_inst (
    .clk, .reset,
    .in_valid, .in_ready, .in_instr,
    .out_valid, .out_ready, .out_result,
    .alu_port(alu_if), .misc_port(misc_if), .pcrel_port(pcrel_if),
    .mem_port(mem_if), .csr_port(csr_if)
  );

  exec_alu alu_inst (.clk, .reset, .port(alu_if));
  exec_misc misc_inst (.clk, .reset, .port(misc_if));
  exec_pcrel pcrel_inst (.clk, .reset, .port(pcrel_if));

  exec_mem mem_inst (
    .clk, .reset, .port(mem_if),
    .mem_req_valid, .mem_req_ready, .mem_req_write,
    .mem_req_addr, .mem_req_wdata, .mem_req_be,
    .mem_resp_valid, .mem_resp_rdata, .mem_resp_ready
  );

  exec_csr csr_inst (
    .clk, .reset, .port(csr_if),
    .csr_req_valid, .csr_req_ready, .csr_req,
    .csr_resp_valid, .csr_resp_rdata
  );

  csr_file csr_file_inst (
    .clk, .reset,
    .csr_req_valid, .csr_req_ready, .csr_req,
    .csr_resp_valid, .csr_resp_rdata
  );

endmodule

//--- sim/tb_exec.sv
module tb_exec import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic reset;
  logic in_valid;
  logic in_ready;
  decoded_instr in_instr;
  logic out_valid;
  logic out_ready;
  exec_result out_result;
  logic mem_req_valid;
  logic mem_req_ready;
  logic mem_req_write;
  xlen_t mem_req_addr;
  xlen_t mem_req_wdata;
  byte_en_t mem_req_be;
  logic mem_resp_valid;
  xlen_t mem_resp_rdata;
  logic mem_resp_ready;

  logic hold_req; // forces mem_req_ready low for the back-pressure test
  xlen_t mem [256];
  xlen_t ref_mem [256];

  exec_top DUT (.*);

  always #50 clk = ~clk;

  function automatic xlen_t fill_word(int i);
    return (xlen_t'(i) * 32'h0101_0101) ^ 32'h5ac3_0000;
  endfunction

  // memory model: samples handshakes at the rising edge, drives on the falling edge
  initial begin : memory_model
    xlen_t req_addr_q;
    int delay;
    logic waiting;
    logic taken;
    for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
    mem_req_ready = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
    waiting = 1'b0;
    delay = 0;
    forever begin
      @(posedge clk);
      if (mem_resp_valid) begin
        check_bit(mem_resp_ready, 1'b1, "mem_resp_ready while a response is offered");
      end
      taken = mem_resp_valid && mem_resp_ready;
      if (mem_req_valid && mem_req_ready) begin
        req_addr_q = mem_req_addr;
        if (mem_req_write) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_req_be[b]) mem[mem_req_addr[9:2]][8*b +: 8] = mem_req_wdata[8*b +: 8];
          end
        end
        delay = $urandom_range(0, 4);
        waiting = 1'b1;
      end
      @(negedge clk);
      if (taken) mem_resp_valid = 1'b0;
      if (waiting) begin
        if (delay == 0) begin
          mem_resp_valid = 1'b1;
          mem_resp_rdata = mem[req_addr_q[9:2]];
          waiting = 1'b0;
        end else begin
          delay--;
        end
      end
      mem_req_ready = hold_req ? 1'b0 : ($urandom_range(0, 3) != 0);
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // fields that the expected record marks as unused are not compared
  task automatic check_result(input exec_result got, input exec_result exp, input string what);
    logic bad;
    bad = got.rd_write !== exp.rd_write || got.redirect !== exp.redirect || got.trap !== exp.trap;
    if (exp.rd_write) bad = bad || got.rd !== exp.rd || got.rd_val !== exp.rd_val;
    if (exp.redirect) bad = bad || got.redirect_target !== exp.redirect_target;
    if (bad) begin
      abort_run({$sformatf("** Error at %0t: %s got wr %b rd %0d val %h redir %b tgt %h trap %b",
                           $time, what, got.rd_write, got.rd, got.rd_val, got.redirect,
                           got.redirect_target, got.trap),
                 $sformatf(", expected wr %b rd %0d val %h redir %b tgt %h trap %b",
                           exp.rd_write, exp.rd, exp.rd_val, exp.redirect,
                           exp.redirect_target, exp.trap)});
    end
  endtask

  function automatic decoded_instr make_instr(instr_op_e op, logic [2:0] f3, logic f7,
                                              reg_idx_t rd, xlen_t rs1, xlen_t rs2,
                                              xlen_t imm, xlen_t pc);
    return '{op: op, funct3: f3, funct7_b5: f7, rd: rd, rs1_val: rs1, rs2_val: rs2,
             imm: imm, pc: pc};
  endfunction

  function automatic exec_result make_result(logic wr, reg_idx_t rd, xlen_t val, logic redir,
                                             xlen_t tgt, logic trap);
    return '{rd_write: wr, rd: rd, rd_val: val, redirect: redir, redirect_target: tgt,
             trap: trap};
  endfunction

  function automatic xlen_t alu_ref(instr_op_e op, logic [2:0] f3, logic f7, xlen_t a,
                                    xlen_t b);
    case (f3)
      3'd0: return (op == INSTR_OP && f7) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return (f7 && a[31]) ? (a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, xlen_t a, xlen_t b);
    logic lt;
    logic ltu;
    lt = $signed(a) < $signed(b);
    ltu = a < b;
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return lt;
      3'b101: return !lt;
      3'b110: return ltu;
      default: return !ltu;
    endcase
  endfunction

  function automatic void store_ref(xlen_t addr, logic [1:0] size, xlen_t data);
    int off;
    off = int'(addr[1:0]);
    for (int b = 0; b < 4; b++) begin
      if (size == 2'd2 || (size == 2'd1 && b / 2 == off / 2) || (size == 2'd0 && b == off)) begin
        ref_mem[addr[9:2]][8*b +: 8] = data[8*(size == 2'd2 ? b : b - off) +: 8];
      end
    end
  endfunction

  function automatic xlen_t load_ref(xlen_t addr, logic [2:0] f3);
    xlen_t sh;
    sh = ref_mem[addr[9:2]] >> (8 * int'(addr[1:0])); // addressed byte moves to bit 0
    case (f3)
      3'b000: return {{24{sh[7]}}, sh[7:0]};
      3'b001: return {{16{sh[15]}}, sh[15:0]};
      3'b100: return {24'b0, sh[7:0]};
      3'b101: return {16'b0, sh[15:0]};
      default: return sh;
    endcase
  endfunction

  task automatic present(input decoded_instr ins);
    @(negedge clk);
    in_instr = ins;
    in_valid = 1'b1;
    #1;
  endtask

  task automatic await_result(output exec_result res);
    int cycles;
    cycles = 0;
    while (out_valid !== 1'b1) begin
      if (cycles == 50) abort_run("timeout: no out_valid within 50 cycles of an instruction");
      @(negedge clk);
      #1;
      cycles++;
    end
    res = out_result;
    @(negedge clk);
    in_valid = 1'b0;
    #1;
  endtask

  task automatic run_instr(input decoded_instr ins, output exec_result res);
    present(ins);
    await_result(res);
  endtask

  task automatic test_alu();
    exec_result got;
    instr_op_e op;
    xlen_t a;
    xlen_t b;
    logic [11:0] imm12;
    for (int k = 0; k < 2; k++) begin
      op = k ? INSTR_OP_IMM : INSTR_OP;
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int s = 0; s < 2; s++) begin
          if (s == 1 && !(f3 == 5 || (f3 == 0 && k == 0))) continue; // only sub and sra use bit 5
          for (int r = 0; r < 4; r++) begin
            a = $urandom();
            imm12 = 12'($urandom());
            b = k ? {{20{imm12[11]}}, imm12} : xlen_t'($urandom());
            run_instr(make_instr(op, 3'(f3), s[0], 5'd4, a, b, b, 32'h100), got);
            check_result(got, make_result(1'b1, 5'd4, alu_ref(op, 3'(f3), s[0], a, b), 1'b0,
                                          '0, 1'b0), "alu");
          end
        end
      end
    end
  endtask

  task automatic test_control_flow();
    exec_result got;
    xlen_t pc;
    xlen_t imm;
    xlen_t a;
    xlen_t x;
    logic taken;
    logic [2:0] conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    xlen_t pair_a [3];
    xlen_t pair_b [3];
    pc = xlen_t'($urandom()) & ~32'h3;
    imm = xlen_t'($urandom()) & 32'hffff_f000;
    run_instr(make_instr(INSTR_LUI, 3'd0, 1'b0, 5'd3, '0, '0, imm, pc), got);
    check_result(got, make_result(1'b1, 5'd3, imm, 1'b0, '0, 1'b0), "lui");
    run_instr(make_instr(INSTR_AUIPC, 3'd0, 1'b0, 5'd3, '0, '0, imm, pc), got);
    check_result(got, make_result(1'b1, 5'd3, pc + imm, 1'b0, '0, 1'b0), "auipc");
    a = $urandom();
    imm = {{11{a[20]}}, a[20:1], 1'b0};
    run_instr(make_instr(INSTR_JAL, 3'd0, 1'b0, 5'd1, '0, '0, imm, pc), got);
    check_result(got, make_result(1'b1, 5'd1, pc + 32'd4, 1'b1, pc + imm, 1'b0), "jal");
    a = $urandom() | 32'd1; // odd rs1 so that bit 0 of the target must be cleared
    imm = {{20{a[11]}}, a[11:1], 1'b0};
    run_instr(make_instr(INSTR_JALR, 3'd0, 1'b0, 5'd1, a, '0, imm, pc), got);
    check_result(got, make_result(1'b1, 5'd1, pc + 32'd4, 1'b1, (a + imm) & 32'hffff_fffe,
                                  1'b0), "jalr");
    x = $urandom();
    pair_a = '{x, 32'hffff_fff0, 32'd5};
    pair_b = '{x, 32'd5, 32'hffff_fff0};
    foreach (conds[c]) begin
      foreach (pair_a[p]) begin
        taken = branch_ref(conds[c], pair_a[p], pair_b[p]);
        run_instr(make_instr(INSTR_BRANCH, conds[c], 1'b0, 5'd2, pair_a[p], pair_b[p], imm, pc),
                  got);
        check_result(got, make_result(1'b0, '0, '0, taken, pc + imm, 1'b0), "branch");
      end
    end
    run_instr(make_instr(INSTR_INVAL, 3'd0, 1'b0, 5'd5, '0, '0, '0, pc), got);
    check_result(got, make_result(1'b0, '0, '0, 1'b0, '0, 1'b1), "invalid op");
    run_instr(make_instr(INSTR_SYSTEM, 3'd0, 1'b0, 5'd5, '0, '0, '0, pc), got);
    check_result(got, make_result(1'b0, '0, '0, 1'b0, '0, 1'b1), "system funct3 zero");
    for (int f3 = 2; f3 < 4; f3++) begin
      run_instr(make_instr(INSTR_BRANCH, 3'(f3), 1'b0, 5'd5, x, x, imm, pc), got);
      check_result(got, make_result(1'b0, '0, '0, 1'b0, '0, 1'b1), "bad branch funct3");
    end
  endtask

  task automatic mem_access(input instr_op_e op, input logic [2:0] f3, input xlen_t addr,
                            input xlen_t data, input reg_idx_t rd, output exec_result got);
    xlen_t imm;
    imm = xlen_t'($urandom_range(0, 63)) - 32'd32;
    run_instr(make_instr(op, f3, 1'b0, rd, addr - imm, data, imm, 32'h1000), got);
  endtask

  task automatic test_memory();
    exec_result got;
    xlen_t base;
    xlen_t addr;
    xlen_t data;
    logic [1:0] size;
    logic [2:0] loads [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    for (int n = 0; n < 12; n++) begin
      size = 2'($urandom_range(0, 2));
      base = xlen_t'($urandom_range(0, 255)) << 2;
      addr = base + (size == 2'd0 ? xlen_t'($urandom_range(0, 3)) :
                     size == 2'd1 ? xlen_t'($urandom_range(0, 1)) << 1 : 32'd0);
      data = $urandom();
      mem_access(INSTR_STORE, {1'b0, size}, addr, data, 5'd6, got);
      store_ref(addr, size, data);
      check_result(got, make_result(1'b0, '0, '0, 1'b0, '0, 1'b0), "store");
      check_word(mem[base[9:2]], ref_mem[base[9:2]], "memory word after store");
      foreach (loads[k]) begin
        for (int off = 0; off < 4; off++) begin
          if (loads[k][1:0] == 2'd1 && off % 2 != 0) continue;
          if (loads[k][1:0] == 2'd2 && off != 0) continue;
          mem_access(INSTR_LOAD, loads[k], base + xlen_t'(off), '0, 5'(n + 1), got);
          check_result(got, make_result(1'b1, 5'(n + 1), load_ref(base + xlen_t'(off), loads[k]),
                                        1'b0, '0, 1'b0), "load");
        end
      end
    end
  endtask

  task automatic test_backpressure();
    exec_result got;
    xlen_t addr;
    xlen_t data;
    xlen_t wdata0;
    addr = xlen_t'($urandom_range(0, 255)) << 2;
    data = $urandom();
    for (int k = 0; k < 2; k++) begin
      hold_req = 1'b1;
      present(make_instr(k ? INSTR_LOAD : INSTR_STORE, k ? 3'b100 : 3'b010, 1'b0, 5'd9, addr,
                         data, k ? 32'd3 : 32'd0, 32'h2000));
      wdata0 = mem_req_wdata;
      repeat (4) begin
        check_bit(mem_req_valid, 1'b1, "mem_req_valid while stalled");
        check_bit(in_ready, 1'b0, "in_ready while stalled");
        check_bit(mem_req_write, k == 0, "stalled request write flag");
        check_word(mem_req_addr, addr + (k ? 32'd3 : 32'd0), "stalled request address");
        check_word(mem_req_wdata, wdata0, "stalled write data");
        @(negedge clk);
        #1;
      end
      hold_req = 1'b0;
      await_result(got);
      if (k == 0) begin
        store_ref(addr, 2'd2, data);
        check_result(got, make_result(1'b0, '0, '0, 1'b0, '0, 1'b0), "stalled store");
        check_word(mem[addr[9:2]], data, "memory word after stalled store");
      end else begin
        check_result(got, make_result(1'b1, 5'd9, load_ref(addr + 32'd3, 3'b100), 1'b0, '0,
                                      1'b0), "stalled load");
      end
    end
  endtask

  task automatic csr_access(input logic [2:0] f3, input csr_addr_t addr, input xlen_t opnd,
                            output exec_result got);
    xlen_t rs1;
    rs1 = f3[2] ? xlen_t'($urandom()) : opnd; // immediate forms must ignore rs1
    run_instr(make_instr(INSTR_SYSTEM, f3, 1'b0, 5'd10, rs1, '0, {15'b0, opnd[4:0], addr},
                         32'h3000), got);
  endtask

  task automatic test_csr();
    exec_result got;
    xlen_t shadow;
    xlen_t opnd;
    xlen_t c1;
    xlen_t c2;
    csr_addr_t addrs [2] = '{CSR_MSCRATCH, CSR_MEPC};
    logic [2:0] forms [6] = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
    foreach (addrs[i]) begin
      shadow = '0;
      for (int rep = 0; rep < 2; rep++) begin
        foreach (forms[f]) begin
          opnd = forms[f][2] ? xlen_t'($urandom_range(0, 31)) : xlen_t'($urandom());
          csr_access(forms[f], addrs[i], opnd, got);
          check_result(got, make_result(1'b1, 5'd10, shadow, 1'b0, '0, 1'b0), "csr old value");
          case (forms[f][1:0])
            2'b01: shadow = opnd;
            2'b10: shadow = shadow | opnd;
            default: shadow = shadow & ~opnd;
          endcase
        end
      end
      csr_access(3'b010, addrs[i], '0, got);
      check_result(got, make_result(1'b1, 5'd10, shadow, 1'b0, '0, 1'b0), "csr final value");
    end
    csr_access(3'b010, CSR_CYCLE, '0, got);
    c1 = got.rd_val;
    csr_access(3'b001, CSR_CYCLE, '0, got); // a write of zero would restart the count
    c2 = got.rd_val;
    if (c2 <= c1) begin
      abort_run($sformatf("** Error at %0t: cycle did not increase from %0d to %0d",
                          $time, c1, c2));
    end
    csr_access(3'b010, CSR_CYCLE, '0, got);
    if (got.rd_val <= c2) begin
      abort_run($sformatf("** Error at %0t: cycle was changed by a write, %0d then %0d",
                          $time, c2, got.rd_val));
    end
  endtask

  initial begin
    void'($urandom(80663));
    reset = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    out_ready = 1'b1;
    hold_req = 1'b0;
    for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i);
    repeat (3) @(negedge clk);
    reset = 1'b0;
    #1;
    check_bit(out_valid, 1'b0, "out_valid after reset");
    check_bit(mem_req_valid, 1'b0, "mem_req_valid after reset");
    test_alu();
    test_control_flow();
    test_memory();
    test_backpressure();
    test_csr();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- filelist.f
logic/exec_pkg.sv
logic/exec_unit_if.sv
logic/exec_dispatch.sv
logic/exec_alu.sv
logic/exec_misc.sv
logic/exec_pcrel.sv
logic/exec_mem.sv
logic/exec_csr.sv
logic/csr_file.sv
logic/exec_top.sv
sim/tb_exec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_exec \
  -f filelist.f \
  --Mdir obj_dir \
  -o tb_exec_sim

./obj_dir/tb_exec_sim 2>&1 | tee sim.log || true

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run_sim.sh: failure reported, see sim.log"
  exit 1
fi

echo "run_sim.sh: no failure reported"
exit 0
